// File: all.f
verilog/mcuBusPkg.sv
verilog/periphPkg.sv
verilog/gpioPort.sv
verilog/pinMux.sv
verilog/timerA.sv
verilog/interruptUnit.sv
verilog/mcuPeriph.sv
tests/tbClock.sv
tests/mcuPeriphTb.sv

// File: tests/mcuPeriphTb.sv
// Testbench for the peripheral top: random bus and pad stimulus, checked against a model.
`timescale 1ns/1ps

module mcuPeriphTb;

    localparam int waitLimit = 600;

    logic              MCLK, rstN, intAck, intReq;
    mcuBusPkg::busReqT bus;
    logic [15:0]       rdata, padIn;
    periphPkg::padCtlT pads;
    logic [5:0]        intVector;

    int                  errors, checks, seedSink, waited, idx;
    logic [15:0]         gpioModel [5]; // pOut, pDir, pRen, pSel0, pSel1.
    logic [4:0]          gpioOffs [5];
    string               gpioNames [5];
    logic [15:0]         iesModel, ieModel, ifgModel, ccr0Model, rd, data, oldPad;
    logic [7:0]          tBits;
    logic [2:0]          outBits;
    logic [1:0]          idBits;
    logic                isByte, hiLane, seen;
    periphPkg::irqLinesT lines;

    tbClock clockGen (.clk(MCLK));

    mcuPeriph uut (
        .MCLK(MCLK), .rstN(rstN), .bus(bus), .rdata(rdata), .padIn(padIn),
        .pads(pads), .intAck(intAck), .intReq(intReq), .intVector(intVector)
    );

    function automatic logic [15:0] gpioAddr(input logic [4:0] off);
        return mcuBusPkg::portABase + 16'(off);
    endfunction

    function automatic logic [15:0] timerAddr(input logic [4:0] off);
        return mcuBusPkg::timerA0Base + 16'(off);
    endfunction

    // Byte data sits on the low lane of wdata.
    function automatic logic [15:0] mergeBytes(input logic [15:0] old, input logic [15:0] wdata,
                                               input logic byteWr, input logic hi);
        if (!byteWr) return wdata;
        return hi ? {wdata[7:0], old[7:0]} : {old[15:8], wdata[7:0]};
    endfunction

    function automatic periphPkg::padCtlT expectedPads(input logic [2:0] tOut);
        periphPkg::padCtlT p;
        logic [1:0] func;
        p.oe   = gpioModel[1];
        p.pull = gpioModel[2];
        p.out  = '0;
        for (int m = 0; m < 16; m++) begin
            func = {gpioModel[4][m], gpioModel[3][m]};
            if (func == 2'd0) p.out[m] = gpioModel[0][m];
            else if (func == 2'd1 && m < 2) p.out[m] = tOut[m + 1];
            else if (func == 2'd2 && m >= 5 && m <= 7) p.out[m] = tOut[m - 5];
        end
        return p;
    endfunction

    function automatic logic [5:0] expectedVector(input periphPkg::irqLinesT l);
        if (l.timerCcr0) return 6'd52;
        if (l.timerOther) return 6'd51;
        if (l.port1) return 6'd45;
        return 6'd42;
    endfunction

    task automatic busWrite(input logic [15:0] addr, input logic [15:0] wdata, input logic byteWr);
        @(negedge MCLK);
        bus.addr      = addr;
        bus.wdata     = wdata;
        bus.write     = 1'b1;
        bus.byteWrite = byteWr;
        @(negedge MCLK);
        bus.write     = 1'b0;
        bus.byteWrite = 1'b0;
    endtask

    task automatic busRead(input logic [15:0] addr, output logic [15:0] value);
        @(negedge MCLK);
        bus.addr  = addr;
        bus.write = 1'b0;
        #10;
        value = rdata;
    endtask

    task automatic compareValue(input string name, input logic [47:0] got,
                                input logic [47:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    initial begin
        gpioOffs  = '{periphPkg::pOut, periphPkg::pDir, periphPkg::pRen,
                      periphPkg::pSel0, periphPkg::pSel1};
        gpioNames = '{"pOut", "pDir", "pRen", "pSel0", "pSel1"};
        foreach (gpioModel[i]) gpioModel[i] = '0;
        errors   = 0;
        checks   = 0;
        seedSink = $urandom(75);
        rstN     = 1'b0;
        bus      = '0;
        padIn    = '0;
        intAck   = 1'b0;
        ifgModel = '0;
        repeat (2) @(negedge MCLK);
        rstN = 1'b1;

        // ------------------------------------------------------------------
        // Reset state and register read-back
        // ------------------------------------------------------------------
        compareValue("intReq", intReq, 1'b0);
        compareValue("pads", pads, '0);
        for (int n = 0; n < 40; n++) begin
            idx    = $urandom_range(4, 0);
            data   = $urandom;
            isByte = $urandom_range(1, 0);
            hiLane = isByte & $urandom_range(1, 0);
            busWrite(gpioAddr(gpioOffs[idx]) | 16'(hiLane), data, isByte);
            gpioModel[idx] = mergeBytes(gpioModel[idx], data, isByte, hiLane);
            busRead(gpioAddr(gpioOffs[idx]), rd);
            compareValue(gpioNames[idx], rd, gpioModel[idx]);
        end

        // Pin mux with the timer stopped and outputs from the out bits.
        for (int n = 0; n < 10; n++) begin
            outBits = $urandom;
            for (int c = 0; c < 3; c++)
                busWrite(timerAddr(periphPkg::tCctl0 + 5'(2 * c)), 16'(outBits[c]) << 2, 1'b0);
            for (int r = 0; r < 5; r++) begin
                gpioModel[r] = $urandom;
                busWrite(gpioAddr(gpioOffs[r]), gpioModel[r], 1'b0);
            end
            compareValue("pads", pads, expectedPads(outBits));
        end

        // ------------------------------------------------------------------
        // Input sync and edge flags
        // ------------------------------------------------------------------
        for (int n = 0; n < 12; n++) begin
            busWrite(gpioAddr(periphPkg::pIfg), 16'h0000, 1'b0); // Start from clear flags.
            ifgModel = '0;
            iesModel = $urandom;
            busWrite(gpioAddr(periphPkg::pIes), iesModel, 1'b0);
            oldPad = padIn;
            @(negedge MCLK);
            padIn = $urandom;
            ifgModel |= (~iesModel & ~oldPad & padIn) | (iesModel & oldPad & ~padIn);
            repeat (2) @(negedge MCLK); // Sync stages, edge seen on the third.
            busRead(gpioAddr(periphPkg::pIn), rd);
            compareValue("pIn", rd, padIn);
            busRead(gpioAddr(periphPkg::pIfg), rd);
            compareValue("pIfg", rd, ifgModel);
        end

        // Interrupt priority over random enabled flags.
        for (int n = 0; n < 12; n++) begin
            tBits    = $urandom;
            ieModel  = $urandom;
            ifgModel = $urandom;
            busWrite(gpioAddr(periphPkg::pIfg), ifgModel, 1'b0);
            busWrite(gpioAddr(periphPkg::pIe), ieModel, 1'b0);
            busWrite(timerAddr(periphPkg::tCtl), {14'b0, tBits[6], tBits[7]}, 1'b0);
            for (int c = 0; c < 3; c++)
                busWrite(timerAddr(periphPkg::tCctl0 + 5'(2 * c)),
                         {11'b0, tBits[2 * c], 3'b0, tBits[2 * c + 1]}, 1'b0);
            lines.timerCcr0  = tBits[0] & tBits[1];
            lines.timerOther = (tBits[2] & tBits[3]) | (tBits[4] & tBits[5]) |
                               (tBits[6] & tBits[7]);
            lines.port1      = |(ieModel[7:0] & ifgModel[7:0]);
            lines.port2      = |(ieModel[15:8] & ifgModel[15:8]);
            @(negedge MCLK); // One registered stage.
            if (lines == '0) begin
                compareValue("intReq", intReq, 1'b0);
            end else begin
                waited = 0;
                while (!intReq && waited < waitLimit) begin
                    @(negedge MCLK);
                    waited++;
                end
                if (!intReq) begin
                    errors++;
                    $display("Timeout: intReq never rose with interrupts enabled");
                end else begin
                    compareValue("intVector", intVector, expectedVector(lines));
                end
            end
            busWrite(gpioAddr(periphPkg::pIe), 16'h0000, 1'b0);
            busWrite(timerAddr(periphPkg::tCtl), 16'h0000, 1'b0);
            for (int c = 0; c < 3; c++)
                busWrite(timerAddr(periphPkg::tCctl0 + 5'(2 * c)), 16'h0000, 1'b0);
        end

        // ------------------------------------------------------------------
        // Up mode, CCR0 interrupt and acknowledge
        // ------------------------------------------------------------------
        for (int n = 0; n < 3; n++) begin
            ccr0Model = $urandom_range(40, 8);
            idBits    = $urandom_range(3, 0);
            busWrite(timerAddr(periphPkg::tCcr0), ccr0Model, 1'b0);
            busWrite(timerAddr(periphPkg::tCctl0), 16'h0090, 1'b0); // Toggle, ccie.
            busWrite(timerAddr(periphPkg::tCtl), 16'h0004, 1'b0);   // Clear count.
            busWrite(timerAddr(periphPkg::tCtl), {8'h00, idBits, 2'b01, 4'h0}, 1'b0);
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < waitLimit) begin
                busRead(timerAddr(periphPkg::tR), rd);
                checks++;
                if (rd > ccr0Model) begin
                    errors++;
                    $display("Mismatch at %0t ns: tR %0h, expected at most %0h",
                             $time, rd, ccr0Model);
                end
                seen = intReq && intVector == 6'd52;
                waited++;
            end
            if (!seen) begin
                errors++;
                $display("Timeout: no CCR0 interrupt request in up mode");
            end else begin
                @(negedge MCLK);
                intAck = 1'b1;
                @(negedge MCLK);
                intAck = 1'b0;
                busRead(timerAddr(periphPkg::tCctl0), rd);
                compareValue("ccifg0", rd[0], 1'b0);
            end
            busWrite(timerAddr(periphPkg::tCtl), 16'h0004, 1'b0); // Stop and clear.
            busWrite(timerAddr(periphPkg::tCctl0), 16'h0000, 1'b0);
        end

        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tests/tbClock.sv
// Free-running testbench clock, 100 ns period, low at time zero.
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    localparam realtime halfPeriod = 50.0;

    initial clk = 1'b0;

    always #(halfPeriod) clk = ~clk;

endmodule

// File: verilog/mcuPeriph.sv
// Peripheral subsystem top: joins GPIO port, Timer_A, pin mux and interrupt unit on one bus.
`timescale 1ns/1ps

module mcuPeriph (
    input  logic              MCLK,
    input  logic              rstN,
    input  mcuBusPkg::busReqT bus,
    output logic [15:0]       rdata,
    input  logic [15:0]       padIn,
    output periphPkg::padCtlT pads,
    input  logic              intAck,
    output logic              intReq,
    output logic [5:0]        intVector
);

    logic [15:0]         gpioRdata, timerRdata;
    logic [15:0]         pOut, pDir, pRen, pSel0, pSel1;
    logic [2:0]          timerOut;
    logic                clrCcr0;
    periphPkg::irqLinesT irq;

    // Unaddressed blocks drive zero.
    assign rdata = gpioRdata | timerRdata;

    gpioPort portA (
        .MCLK(MCLK), .rstN(rstN),
        .bus(bus), .rdata(gpioRdata),
        .padIn(padIn),
        .pOut(pOut), .pDir(pDir), .pRen(pRen), .pSel0(pSel0), .pSel1(pSel1),
        .port1Irq(irq.port1), .port2Irq(irq.port2)
    );

    timerA timerA0 (
        .MCLK(MCLK), .rstN(rstN),
        .bus(bus), .rdata(timerRdata),
        .clrCcr0(clrCcr0),
        .timerOut(timerOut),
        .ccr0Irq(irq.timerCcr0), .otherIrq(irq.timerOther)
    );

    pinMux mux (
        .pOut(pOut), .pDir(pDir), .pRen(pRen), .pSel0(pSel0), .pSel1(pSel1),
        .timerOut(timerOut),
        .pads(pads)
    );

    interruptUnit intUnit (
        .MCLK(MCLK), .rstN(rstN),
        .irq(irq), .intAck(intAck),
        .intReq(intReq), .intVector(intVector),
        .clrCcr0(clrCcr0)
    );

endmodule

// File: verilog/interruptUnit.sv
// Interrupt unit: prioritises peripheral requests, registers the vector, clears on acknowledge.
`timescale 1ns/1ps

module interruptUnit (
    input  logic                MCLK,
    input  logic                rstN,
    input  periphPkg::irqLinesT irq,
    input  logic                intAck,
    output logic                intReq,
    output logic [5:0]          intVector,
    output logic                clrCcr0
);

    logic       anyReq;
    logic [5:0] winner;

    // ----------------------------------------------------------------------
    // Priority encoder, highest vector first
    // ----------------------------------------------------------------------
    always_comb begin
        if (irq.timerCcr0) begin
            winner = periphPkg::vecTimerCcr0;
        end else if (irq.timerOther) begin
            winner = periphPkg::vecTimerOther;
        end else if (irq.port1) begin
            winner = periphPkg::vecPort1;
        end else if (irq.port2) begin
            winner = periphPkg::vecPort2;
        end else begin
            winner = 6'd0;
        end
    end

    assign anyReq = |irq;

    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            intReq    <= 1'b0;
            intVector <= 6'd0;
        end else begin
            intReq    <= anyReq;
            intVector <= winner;
        end
    end

    // Only the CCR0 source is cleared by hardware; the others need a flag write.
    assign clrCcr0 = intAck && (intVector == periphPkg::vecTimerCcr0);

endmodule

// File: verilog/timerA.sv
// Timer_A block on the peripheral bus: prescaler, counter, three compare channels and outputs.
`timescale 1ns/1ps

module timerA (
    input  logic              MCLK,
    input  logic              rstN,
    input  mcuBusPkg::busReqT bus,
    output logic [15:0]       rdata,
    input  logic              clrCcr0,
    output logic [2:0]        timerOut,
    output logic              ccr0Irq,
    output logic              otherIrq
);

    localparam int nCh = periphPkg::ccmCount;
    localparam logic [4:0] cctlOffs [nCh] = '{periphPkg::tCctl0, periphPkg::tCctl1,
                                              periphPkg::tCctl2};
    localparam logic [4:0] ccrOffs [nCh] = '{periphPkg::tCcr0, periphPkg::tCcr1,
                                             periphPkg::tCcr2};

    logic                      sel, wrEn, taclrHit, tick, step, wrap;
    logic [4:0]                regOff;
    logic [15:0]               ctl, ctlNext, ctlWr, tRCount, nextR;
    logic [2:0]                presc, divMask;
    logic [nCh-1:0][15:0]      cctl, cctlNext, ccr;
    logic [nCh-1:0]            ccMatch, outQ;
    periphPkg::timerModeT      mode;
    periphPkg::outModeT        outMode [nCh];

    assign sel    = mcuBusPkg::inBlock(bus.addr, mcuBusPkg::timerA0Base);
    assign wrEn   = sel && bus.write;
    assign regOff = 5'(bus.addr - mcuBusPkg::timerA0Base) & 5'h1E;

    // ----------------------------------------------------------------------
    // Mode decode and count step
    // ----------------------------------------------------------------------
    assign mode = (ctl[periphPkg::mcMsb:periphPkg::mcLsb] == 2'd3) ? periphPkg::tmStop :
                  periphPkg::timerModeT'(ctl[periphPkg::mcMsb:periphPkg::mcLsb]);
    assign divMask  = 3'((4'd1 << ctl[periphPkg::idMsb:periphPkg::idLsb]) - 4'd1);
    assign tick     = (presc & divMask) == divMask;
    assign ctlWr    = mcuBusPkg::mergeWrite(ctl, bus);
    assign taclrHit = wrEn && regOff == periphPkg::tCtl && ctlWr[periphPkg::taclrBit];
    assign step     = tick && mode != periphPkg::tmStop && !taclrHit;

    // Up mode also rolls over if tCcr0 was moved below the count.
    assign nextR = (mode == periphPkg::tmUp && tRCount >= ccr[0]) ? 16'h0000 : tRCount + 16'd1;
    assign wrap  = step && nextR == 16'h0000;

    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            presc   <= '0;
            tRCount <= '0;
        end else if (taclrHit) begin
            presc   <= '0;
            tRCount <= '0;
        end else begin
            presc <= presc + 3'd1;
            if (step) tRCount <= nextR;
        end
    end

    // ----------------------------------------------------------------------
    // Control and compare registers
    // ----------------------------------------------------------------------
    always_comb begin
        ctlNext = (wrEn && regOff == periphPkg::tCtl) ? ctlWr : ctl;
        ctlNext[periphPkg::taclrBit] = 1'b0; // Self clearing.
        if (wrap) ctlNext[periphPkg::taifgBit] = 1'b1;
        for (int n = 0; n < nCh; n++) begin
            ccMatch[n]  = step && nextR == ccr[n];
            cctlNext[n] = (wrEn && regOff == cctlOffs[n]) ?
                          mcuBusPkg::mergeWrite(cctl[n], bus) : cctl[n];
            if (n == 0 && clrCcr0) cctlNext[n][periphPkg::ccifgBit] = 1'b0;
            if (ccMatch[n]) cctlNext[n][periphPkg::ccifgBit] = 1'b1;
            outMode[n] = periphPkg::outModeT'(cctl[n][periphPkg::outmodMsb:periphPkg::outmodLsb]);
        end
    end

    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            ctl  <= '0;
            cctl <= '0;
            ccr  <= '0;
        end else begin
            ctl  <= ctlNext;
            cctl <= cctlNext;
            for (int n = 0; n < nCh; n++) begin
                if (wrEn && regOff == ccrOffs[n]) ccr[n] <= mcuBusPkg::mergeWrite(ccr[n], bus);
            end
        end
    end

    // Output units.
    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            outQ <= '0;
        end else begin
            for (int n = 0; n < nCh; n++) begin
                if (outMode[n] == periphPkg::omOutBit) outQ[n] <= cctl[n][periphPkg::outBitPos];
                else if (ccMatch[n]) begin
                    case (outMode[n])
                        periphPkg::omSet:    outQ[n] <= 1'b1;
                        periphPkg::omToggle: outQ[n] <= ~outQ[n];
                        periphPkg::omReset:  outQ[n] <= 1'b0;
                        default:             outQ[n] <= outQ[n]; // Hold.
                    endcase
                end
            end
        end
    end

    always_comb begin
        for (int n = 0; n < nCh; n++) begin
            timerOut[n] = (outMode[n] == periphPkg::omOutBit) ?
                          cctl[n][periphPkg::outBitPos] : outQ[n];
        end
    end

    assign ccr0Irq  = cctl[0][periphPkg::ccieBit] && cctl[0][periphPkg::ccifgBit];
    assign otherIrq = (ctl[periphPkg::taieBit] && ctl[periphPkg::taifgBit]) ||
                      (cctl[1][periphPkg::ccieBit] && cctl[1][periphPkg::ccifgBit]) ||
                      (cctl[2][periphPkg::ccieBit] && cctl[2][periphPkg::ccifgBit]);

    always_comb begin
        rdata = '0;
        if (sel) begin
            if (regOff == periphPkg::tCtl) rdata = ctl;
            if (regOff == periphPkg::tR) rdata = tRCount;
            for (int n = 0; n < nCh; n++) begin
                if (regOff == cctlOffs[n]) rdata = cctl[n];
                if (regOff == ccrOffs[n]) rdata = ccr[n];
            end
        end
    end

endmodule

// File: verilog/pinMux.sv
// Pin function multiplexer: picks GPIO or timer output drive for each of the 16 pins.
`timescale 1ns/1ps

module pinMux (
    input  logic [15:0]       pOut,
    input  logic [15:0]       pDir,
    input  logic [15:0]       pRen,
    input  logic [15:0]       pSel0,
    input  logic [15:0]       pSel1,
    input  logic [2:0]        timerOut,
    output periphPkg::padCtlT pads
);

    logic [15:0] lowMap;
    logic [15:0] highMap;

    // Secondary function: out1 on pin 0, out2 on pin 1.
    assign lowMap = {14'b0, timerOut[2], timerOut[1]};

    // Tertiary function: out0..out2 on pins 5..7.
    assign highMap = {8'b0, timerOut, 5'b0};

    always_comb begin
        periphPkg::pinFuncT func;
        pads.oe   = pDir;
        pads.pull = pRen;
        pads.out  = '0;
        for (int m = 0; m < 16; m++) begin
            func = periphPkg::pinFuncT'({pSel1[m], pSel0[m]});
            case (func)
                periphPkg::pfGpio:         pads.out[m] = pOut[m];
                periphPkg::pfTimerOutLow:  pads.out[m] = lowMap[m];
                periphPkg::pfTimerOutHigh: pads.out[m] = highMap[m];
                default:                   pads.out[m] = 1'b0; // Unmapped selection.
            endcase
        end
    end

endmodule

// File: verilog/gpioPort.sv
// 16-bit GPIO port on the peripheral bus: pin registers, input sync and edge interrupts.
`timescale 1ns/1ps

module gpioPort (
    input  logic               MCLK,
    input  logic               rstN,
    input  mcuBusPkg::busReqT  bus,
    output logic [15:0]        rdata,
    input  logic [15:0]        padIn,
    output logic [15:0]        pOut,
    output logic [15:0]        pDir,
    output logic [15:0]        pRen,
    output logic [15:0]        pSel0,
    output logic [15:0]        pSel1,
    output logic               port1Irq,
    output logic               port2Irq
);

    logic        sel, wrEn;
    logic [4:0]  regOff;
    logic [15:0] syncMeta, syncIn, prevIn;
    logic [15:0] pIes, pIe, pIfg;
    logic [15:0] edgeSet;

    assign sel    = mcuBusPkg::inBlock(bus.addr, mcuBusPkg::portABase);
    assign wrEn   = sel && bus.write;
    assign regOff = 5'(bus.addr - mcuBusPkg::portABase) & 5'h1E; // Word offset.

    // ----------------------------------------------------------------------
    // Input path
    // ----------------------------------------------------------------------
    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            syncMeta <= '0;
            syncIn   <= '0;
            prevIn   <= '0;
        end else begin
            syncMeta <= padIn;
            syncIn   <= syncMeta;
            prevIn   <= syncIn;
        end
    end

    // pIes 0 picks rising edges, 1 falling.
    assign edgeSet = (~pIes & syncIn & ~prevIn) | (pIes & ~syncIn & prevIn);

    // ----------------------------------------------------------------------
    // Registers
    // ----------------------------------------------------------------------
    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            pOut  <= '0;
            pDir  <= '0;
            pRen  <= '0;
            pSel0 <= '0;
            pSel1 <= '0;
            pIes  <= '0;
            pIe   <= '0;
        end else if (wrEn) begin
            case (regOff)
                periphPkg::pOut:  pOut  <= mcuBusPkg::mergeWrite(pOut, bus);
                periphPkg::pDir:  pDir  <= mcuBusPkg::mergeWrite(pDir, bus);
                periphPkg::pRen:  pRen  <= mcuBusPkg::mergeWrite(pRen, bus);
                periphPkg::pSel0: pSel0 <= mcuBusPkg::mergeWrite(pSel0, bus);
                periphPkg::pSel1: pSel1 <= mcuBusPkg::mergeWrite(pSel1, bus);
                periphPkg::pIes:  pIes  <= mcuBusPkg::mergeWrite(pIes, bus);
                periphPkg::pIe:   pIe   <= mcuBusPkg::mergeWrite(pIe, bus);
                default: ;
            endcase
        end
    end

    // New edges win over a clearing write in the same cycle.
    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            pIfg <= '0;
        end else if (wrEn && regOff == periphPkg::pIfg) begin
            pIfg <= mcuBusPkg::mergeWrite(pIfg, bus) | edgeSet;
        end else begin
            pIfg <= pIfg | edgeSet;
        end
    end

    assign port1Irq = |(pIe[7:0] & pIfg[7:0]);
    assign port2Irq = |(pIe[15:8] & pIfg[15:8]);

    always_comb begin
        rdata = '0;
        if (sel) begin
            case (regOff)
                periphPkg::pIn:   rdata = syncIn;
                periphPkg::pOut:  rdata = pOut;
                periphPkg::pDir:  rdata = pDir;
                periphPkg::pRen:  rdata = pRen;
                periphPkg::pSel0: rdata = pSel0;
                periphPkg::pSel1: rdata = pSel1;
                periphPkg::pIes:  rdata = pIes;
                periphPkg::pIe:   rdata = pIe;
                periphPkg::pIfg:  rdata = pIfg;
                default:          rdata = '0;
            endcase
        end
    end

endmodule

// File: verilog/periphPkg.sv
// Peripheral register offsets, field positions, mode encodings and pad/interrupt structs.
package periphPkg;

    // GPIO register offsets within the port block.
    localparam logic [4:0] pIn   = 5'h00;
    localparam logic [4:0] pOut  = 5'h02;
    localparam logic [4:0] pDir  = 5'h04;
    localparam logic [4:0] pRen  = 5'h06;
    localparam logic [4:0] pSel0 = 5'h0A;
    localparam logic [4:0] pSel1 = 5'h0C;
    localparam logic [4:0] pIes  = 5'h18;
    localparam logic [4:0] pIe   = 5'h1A;
    localparam logic [4:0] pIfg  = 5'h1C;

    // Timer register offsets.
    localparam logic [4:0] tCtl   = 5'h00;
    localparam logic [4:0] tCctl0 = 5'h02;
    localparam logic [4:0] tCctl1 = 5'h04;
    localparam logic [4:0] tCctl2 = 5'h06;
    localparam logic [4:0] tR     = 5'h10;
    localparam logic [4:0] tCcr0  = 5'h12;
    localparam logic [4:0] tCcr1  = 5'h14;
    localparam logic [4:0] tCcr2  = 5'h16;

    // ----------------------------------------------------------------------
    // Control fields
    // ----------------------------------------------------------------------
    localparam int idMsb = 7, idLsb = 6, mcMsb = 5, mcLsb = 4;
    localparam int taclrBit = 2, taieBit = 1, taifgBit = 0;
    localparam int outmodMsb = 7, outmodLsb = 5, ccieBit = 4, outBitPos = 2, ccifgBit = 0;

    localparam int ccmCount = 3;

    typedef enum logic [1:0] {tmStop = 2'd0, tmUp = 2'd1, tmContinuous = 2'd2} timerModeT;
    typedef enum logic [2:0] {omOutBit = 3'd0, omSet = 3'd1, omToggle = 3'd4,
                              omReset = 3'd5} outModeT;
    typedef enum logic [1:0] {pfGpio = 2'd0, pfTimerOutLow = 2'd1,
                              pfTimerOutHigh = 2'd2} pinFuncT;

    typedef struct packed {
        logic timerCcr0;
        logic timerOther;
        logic port1;
        logic port2;
    } irqLinesT;

    typedef struct packed {
        logic [15:0] out;
        logic [15:0] oe;
        logic [15:0] pull;
    } padCtlT;

    localparam logic [5:0] vecTimerCcr0 = 6'd52, vecTimerOther = 6'd51;
    localparam logic [5:0] vecPort1 = 6'd45, vecPort2 = 6'd42;

endpackage

// File: verilog/mcuBusPkg.sv
// Peripheral bus definitions: cycle struct, widths, memory map and byte-lane merge helpers.
package mcuBusPkg;

    localparam int addrWidth = 16;
    localparam int dataWidth = 16;

    // One bus cycle as driven by the master.
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
        logic                 write;     // MW strobe.
        logic                 byteWrite; // BW, lane chosen by addr[0].
    } busReqT;

    // ----------------------------------------------------------------------
    // Memory map
    // ----------------------------------------------------------------------
    localparam logic [addrWidth-1:0] portABase   = 16'h0200;
    localparam logic [addrWidth-1:0] timerA0Base = 16'h0340;
    localparam logic [addrWidth-1:0] blockSpan   = 16'h0020;

    function automatic logic inBlock(logic [addrWidth-1:0] addr, logic [addrWidth-1:0] base);
        return (addr >= base) && (addr < base + blockSpan);
    endfunction

    // Byte data always rides on the low lane, as the CPU puts it there.
    function automatic logic [dataWidth-1:0] mergeWrite(logic [dataWidth-1:0] old,
                                                        busReqT req);
        logic [dataWidth-1:0] res;
        res = req.wdata;
        if (req.byteWrite) begin
            res = old;
            if (req.addr[0]) res[15:8] = req.wdata[7:0];
            else res[7:0] = req.wdata[7:0];
        end
        return res;
    endfunction

endpackage
